// ==== hpdcache_to_l15.sv ====
/*
 * Cache memory port to L1.5 adapter, loads and stores only.
 * At most two requests in flight; all outputs are combinational.
 */
module hpdcache_to_l15 import l15_adapter_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  mem_req_t  req_i,

    output logic      resp_valid_o,
    input  logic      resp_ready_i,
    output mem_resp_t resp_o,

    output l15_req_t  l15_req_o,
    input  logic      l15_ack_i,
    input  l15_rtrn_t l15_rtrn_i,
    output logic      l15_req_ack_o
);

    l15_req_t  l15_fields;
    logic      slot_free;
    logic      slot_tid;
    slot_tag_t rtrn_tag;

    l15_req_translator i_req_translator (
        .req_i        (req_i),
        .l15_fields_o (l15_fields)
    );

    l15_thread_table i_thread_table (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .req_valid_i  (req_valid_i),
        .l15_ack_i    (l15_ack_i),
        .req_tag_i    ({req_i.id, req_i.pid}),
        .rtrn_val_i   (l15_rtrn_i.val),
        .rtrn_tid_i   (l15_rtrn_i.threadid),
        .resp_ready_i (resp_ready_i),
        .free_o       (slot_free),
        .tid_o        (slot_tid),
        .tag_o        (rtrn_tag)
    );

    l15_resp_translator i_resp_translator (
        .l15_rtrn_i    (l15_rtrn_i),
        .tag_i         (rtrn_tag),
        .resp_ready_i  (resp_ready_i),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .l15_req_ack_o (l15_req_ack_o)
    );

    assign req_ready_o = l15_ack_i & slot_free;

    always_comb begin
        l15_req_o          = l15_fields;
        l15_req_o.val      = req_valid_i & slot_free;  // No request without a slot
        l15_req_o.threadid = slot_tid;
    end

endmodule

// ==== l15_adapter_pkg.sv ====
/*
 * Shared widths, L1.5 encodings and payload structs for the cache to L1.5 adapter.
 * Only loads and stores are encoded; the L1.5 thread id is a single bit (two slots).
 */
package l15_adapter_pkg;

    localparam int unsigned PA_WIDTH     = 40;
    localparam int unsigned DW_WIDTH     = 64;
    localparam int unsigned BE_WIDTH     = DW_WIDTH / 8;
    localparam int unsigned MEM_ID_WIDTH = 4;
    localparam int unsigned PID_WIDTH    = 2;
    localparam int unsigned RTRN_DWORDS  = 4;
    localparam bit          SWAP_ENDIAN  = 1'b1;  // Cache side is little endian, L1.5 big endian

    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        L15_LOAD_RET  = 4'b0000,
        L15_STORE_ACK = 4'b0100,
        L15_ERR_RET   = 4'b1100
    } l15_rtntype_e;

    typedef struct packed {
        logic [PA_WIDTH-1:0]     addr;
        logic [2:0]              size;       // log2 of bytes, 4 means 16 bytes
        logic [MEM_ID_WIDTH-1:0] id;
        logic [PID_WIDTH-1:0]    pid;
        logic                    cacheable;
        logic                    is_write;
        logic [DW_WIDTH-1:0]     wdata;
        logic [BE_WIDTH-1:0]     be;
        logic                    pad;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_ID_WIDTH-1:0]         id;
        logic [PID_WIDTH-1:0]            pid;
        logic                            error;
        logic [RTRN_DWORDS*DW_WIDTH-1:0] rdata;
    } mem_resp_t;

    typedef struct packed {
        logic                val;
        l15_rqtype_e         rqtype;
        logic                nc;
        logic [2:0]          size;
        logic                threadid;
        logic [PA_WIDTH-1:0] address;
        logic [DW_WIDTH-1:0] data;
        logic                pad;
    } l15_req_t;

    typedef struct packed {
        logic                                 val;
        l15_rtntype_e                         returntype;
        logic                                 threadid;
        logic [RTRN_DWORDS-1:0][DW_WIDTH-1:0] data;  // data[0] is the lowest doubleword
    } l15_rtrn_t;

    typedef struct packed {
        logic [MEM_ID_WIDTH-1:0] id;
        logic [PID_WIDTH-1:0]    pid;
    } slot_tag_t;

    // Byte reversal within one doubleword
    function automatic logic [DW_WIDTH-1:0] swap_bytes64(input logic [DW_WIDTH-1:0] d);
        logic [DW_WIDTH-1:0] s;
        for (int i = 0; i < BE_WIDTH; i++) begin
            s[8*i +: 8] = d[8*(BE_WIDTH-1-i) +: 8];
        end
        return s;
    endfunction

endpackage

// ==== l15_req_translator.sv ====
/*
 * Maps a cache load or store onto L1.5 request fields.
 * val and threadid are left at zero and filled in by the top level.
 */
module l15_req_translator import l15_adapter_pkg::*; (
    input  mem_req_t req_i,
    output l15_req_t l15_fields_o
);

    logic [2:0]          st_size;
    logic [PA_WIDTH-1:0] st_addr;
    logic [DW_WIDTH-1:0] st_data;
    logic [DW_WIDTH-1:0] raw_data;

    l15_store_encoder i_store_encoder (
        .be_i    (req_i.be),
        .addr_i  (req_i.addr),
        .wdata_i (req_i.wdata),
        .size_o  (st_size),
        .addr_o  (st_addr),
        .data_o  (st_data)
    );

    always_comb begin
        l15_fields_o    = '0;
        l15_fields_o.nc = ~req_i.cacheable;
        if (req_i.is_write) begin
            l15_fields_o.rqtype  = L15_STORE_RQ;
            l15_fields_o.size    = st_size;
            l15_fields_o.address = st_addr;
            raw_data             = st_data;
        end else begin
            l15_fields_o.rqtype  = L15_LOAD_RQ;
            // 16 byte loads use the L1.5 line size code
            l15_fields_o.size    = (req_i.size == 3'd4) ? 3'd7 : req_i.size;
            l15_fields_o.address = req_i.addr;
            raw_data             = req_i.wdata;  // Ignored by the L1.5 on loads
        end

        if (SWAP_ENDIAN) begin
            l15_fields_o.data = swap_bytes64(raw_data);
        end else begin
            l15_fields_o.data = raw_data;
        end
    end

endmodule

// ==== l15_resp_translator.sv ====
/*
 * Turns an L1.5 return into a cache response. The whole 32 byte payload
 * arrives in one beat; the L1.5 holds it until l15_req_ack_o.
 */
module l15_resp_translator import l15_adapter_pkg::*; (
    input  l15_rtrn_t l15_rtrn_i,
    input  slot_tag_t tag_i,
    input  logic      resp_ready_i,
    output logic      resp_valid_o,
    output mem_resp_t resp_o,
    output logic      l15_req_ack_o
);

    assign resp_valid_o  = l15_rtrn_i.val;
    assign l15_req_ack_o = l15_rtrn_i.val & resp_ready_i;  // Consumed only when accepted

    always_comb begin
        resp_o.id    = tag_i.id;
        resp_o.pid   = tag_i.pid;
        resp_o.error = (l15_rtrn_i.returntype == L15_ERR_RET);
        for (int i = 0; i < RTRN_DWORDS; i++) begin
            // Doubleword order is kept, bytes swapped inside each one
            if (SWAP_ENDIAN) begin
                resp_o.rdata[DW_WIDTH*i +: DW_WIDTH] = swap_bytes64(l15_rtrn_i.data[i]);
            end else begin
                resp_o.rdata[DW_WIDTH*i +: DW_WIDTH] = l15_rtrn_i.data[i];
            end
        end
    end

endmodule

// ==== l15_store_encoder.sv ====
/*
 * Store size and offset from the byte enables. Contiguous 1/2/4/8 byte groups
 * are assumed aligned to their size; other patterns go out as size 7, address unchanged.
 */
module l15_store_encoder import l15_adapter_pkg::*; (
    input  logic [BE_WIDTH-1:0] be_i,
    input  logic [PA_WIDTH-1:0] addr_i,
    input  logic [DW_WIDTH-1:0] wdata_i,
    output logic [2:0]          size_o,
    output logic [PA_WIDTH-1:0] addr_o,
    output logic [DW_WIDTH-1:0] data_o
);

    logic [3:0] num_ones;
    logic [2:0] first_pos;   // Lowest enabled byte lane
    logic [2:0] offset;
    logic [2:0] lane_mask;   // Byte lanes inside one chunk, minus one

    assign num_ones = 4'($countones(be_i));

    always_comb begin
        first_pos = '0;
        for (int i = BE_WIDTH - 1; i >= 0; i--) begin
            if (be_i[i]) begin
                first_pos = 3'(i);
            end
        end
    end

    always_comb begin
        addr_o = addr_i;
        unique case (num_ones)
            4'd1: begin
                size_o    = 3'd0;
                offset    = first_pos;
                lane_mask = 3'b000;
            end
            4'd2: begin
                size_o    = 3'd1;
                offset    = {first_pos[2:1], 1'b0};
                lane_mask = 3'b001;
            end
            4'd4: begin
                size_o    = 3'd2;
                offset    = {first_pos[2], 2'b00};
                lane_mask = 3'b011;
            end
            4'd8: begin
                size_o    = 3'd3;
                offset    = 3'b000;
                lane_mask = 3'b111;
            end
            default: begin
                size_o    = 3'd7;  // Irregular mask, whole doubleword
                offset    = 3'b000;
                lane_mask = 3'b111;
            end
        endcase
        if (size_o != 3'd7) begin
            addr_o = {addr_i[PA_WIDTH-1:3], offset};
        end
    end

    // Each lane picks the matching byte of the enabled chunk
    always_comb begin
        logic [2:0] src;
        for (int i = 0; i < BE_WIDTH; i++) begin
            src = (offset & ~lane_mask) | (3'(i) & lane_mask);
            data_o[8*i +: 8] = wdata_i[8*src +: 8];
        end
    end

endmodule

// ==== l15_thread_table.sv ====
/*
 * Two L1.5 thread slots used as request credits. Each busy slot keeps the
 * requester id and port id until its return is consumed. A freed slot is reusable next cycle.
 */
module l15_thread_table import l15_adapter_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      req_valid_i,
    input  logic      l15_ack_i,
    input  slot_tag_t req_tag_i,
    input  logic      rtrn_val_i,
    input  logic      rtrn_tid_i,
    input  logic      resp_ready_i,
    output logic      free_o,
    output logic      tid_o,
    output slot_tag_t tag_o
);

    // Bit n set means slot n is busy
    typedef enum logic [1:0] {
        SLOTS_FREE = 2'b00,
        SLOT0_BUSY = 2'b01,
        SLOT1_BUSY = 2'b10,
        SLOTS_BUSY = 2'b11
    } slot_state_e;

    slot_state_e state_q, state_d;
    slot_tag_t   tag_q [2];
    logic        accept;
    logic        consume;

    assign accept  = req_valid_i & l15_ack_i & free_o;
    assign consume = rtrn_val_i & resp_ready_i;

    assign free_o = (state_q != SLOTS_BUSY);
    assign tid_o  = state_q[0];   // Slot 1 whenever slot 0 is taken

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            SLOTS_FREE: begin
                if (accept) begin
                    state_d = SLOT0_BUSY;
                end
            end
            SLOT0_BUSY: begin
                if (accept && consume) begin
                    state_d = SLOT1_BUSY;   // Slot 0 returns, slot 1 taken
                end else if (consume) begin
                    state_d = SLOTS_FREE;
                end else if (accept) begin
                    state_d = SLOTS_BUSY;
                end
            end
            SLOT1_BUSY: begin
                if (accept && consume) begin
                    state_d = SLOT0_BUSY;
                end else if (consume) begin
                    state_d = SLOTS_FREE;
                end else if (accept) begin
                    state_d = SLOTS_BUSY;
                end
            end
            SLOTS_BUSY: begin
                if (consume) begin
                    state_d = rtrn_tid_i ? SLOT0_BUSY : SLOT1_BUSY;
                end
            end
            default: state_d = SLOTS_FREE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SLOTS_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            tag_q[tid_o] <= req_tag_i;
        end
    end

    assign tag_o = tag_q[rtrn_tid_i];

endmodule

// ==== run.sh ====
#!/bin/sh
# Compiles with Verilator, runs, and exits non-zero unless the pass line is printed
verilator --binary --timing --timescale 1ns/1ps -f sim.f \
    --top-module tb_hpdcache_to_l15 -o tb_sim &&
    ./obj_dir/tb_sim | tee /dev/stderr | grep -q "RESULT: PASS" ||
    { echo "Simulation failed"; exit 1; }

// ==== sim.f ====
l15_adapter_pkg.sv
l15_store_encoder.sv
l15_req_translator.sv
l15_thread_table.sv
l15_resp_translator.sv
hpdcache_to_l15.sv
tb_clock_gen.sv
tb_hpdcache_to_l15.sv

// ==== tb_clock_gen.sv ====
/*
 * 100 ns clock. Reset is held low over the first 3 rising edges
 * and released 10 ns after the third one.
 */
module tb_clock_gen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 rst_no = 1'b1;
    end

endmodule

// ==== tb_hpdcache_to_l15.sv ====
/*
 * Testbench for hpdcache_to_l15 with a small L1.5 model that returns in random slot order.
 * Inputs change 10 ns after the rising edge, outputs are compared at the falling edge.
 */
module tb_hpdcache_to_l15 import l15_adapter_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_LOADS  = 40;
    localparam int NUM_RANDOM = 150;
    localparam int MAX_CYCLES = 4000;  // Roughly ten times the expected run

    typedef logic [271:0] cmp_t;

    logic      clk, rst_n;
    logic      req_valid, req_ready, resp_valid, resp_ready, l15_ack, l15_req_ack;
    mem_req_t  req;
    mem_resp_t resp;
    l15_req_t  l15_req;
    l15_rtrn_t l15_rtrn;

    logic       busy [2];     // Slot state as tracked by the L1.5 model
    slot_tag_t  tag_rec [2];  // Id and port id recorded per threadid
    logic       rtrn_done, rtrn_enable, random_flow;
    int         checks, errors, requests, returns, cycles;
    logic [7:0] odd_be [6] = '{8'h05, 8'h70, 8'h07, 8'hFE, 8'h81, 8'h3C};

    tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

    hpdcache_to_l15 uut (
        .clk_i(clk), .rst_ni(rst_n),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_o(resp),
        .l15_req_o(l15_req), .l15_ack_i(l15_ack), .l15_rtrn_i(l15_rtrn),
        .l15_req_ack_o(l15_req_ack)
    );

    function automatic logic [63:0] reverse_bytes(input logic [63:0] d);
        return {<<8{d}};
    endfunction

    // Expected L1.5 request, from the load and store encoding rules
    function automatic l15_req_t expected_req(input mem_req_t r, input logic tid);
        l15_req_t    e;
        logic [63:0] d;
        int          n, low, chunk, off;
        e          = '0;
        e.val      = 1'b1;
        e.threadid = tid;
        e.nc       = ~r.cacheable;
        if (!r.is_write) begin
            e.rqtype  = L15_LOAD_RQ;
            e.size    = (r.size == 3'd4) ? 3'd7 : r.size;
            e.address = r.addr;
            d         = r.wdata;
        end else begin
            n   = $countones(r.be);
            low = 0;
            while (low < 7 && !r.be[low]) low++;
            chunk = (n == 1 || n == 2 || n == 4 || n == 8) ? n : 8;
            off   = (chunk == 8) ? 0 : low - (low % chunk);
            case (n)
                1: e.size = 3'd0;
                2: e.size = 3'd1;
                4: e.size = 3'd2;
                8: e.size = 3'd3;
                default: e.size = 3'd7;
            endcase
            e.rqtype  = L15_STORE_RQ;
            e.address = (e.size == 3'd7) ? r.addr : {r.addr[PA_WIDTH-1:3], 3'(off)};
            for (int i = 0; i < 8; i++) begin
                d[8*i +: 8] = r.wdata[8*(off + i % chunk) +: 8];  // Chunk repeated per lane
            end
        end
        e.data = SWAP_ENDIAN ? reverse_bytes(d) : d;
        return e;
    endfunction

    function automatic mem_resp_t expected_resp(input l15_rtrn_t t, input slot_tag_t tag);
        mem_resp_t e;
        e.id    = tag.id;
        e.pid   = tag.pid;
        e.error = (t.returntype == L15_ERR_RET);
        for (int i = 0; i < RTRN_DWORDS; i++) begin
            e.rdata[64*i +: 64] = SWAP_ENDIAN ? reverse_bytes(t.data[i]) : t.data[i];
        end
        return e;
    endfunction

    function automatic mem_req_t random_req(input logic write, input logic [7:0] be);
        mem_req_t r;
        r.addr      = {8'($urandom), $urandom};
        r.size      = 3'($urandom_range(4));
        r.id        = 4'($urandom);
        r.pid       = 2'($urandom);
        r.cacheable = 1'($urandom);
        r.is_write  = write;
        r.wdata     = {$urandom, $urandom};
        r.be        = be;
        r.pad       = 1'b0;
        return r;
    endfunction

    task automatic check(input string what, input cmp_t got, input cmp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0d ns: %s: got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Holds the request until the adapter accepts it
    task automatic send_req(input mem_req_t r);
        logic accepted;
        req       = r;
        req_valid = 1'b1;
        do begin
            @(negedge clk);
            accepted = req_ready;
            @(posedge clk);
            #10;
        end while (!accepted);
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #10;
        end while (busy[0] || busy[1]);
    endtask

    // Compare process that also keeps the slot state of the L1.5 model
    always @(negedge clk) begin
        logic free;
        logic exp_tid;
        logic accepted;
        if (rst_n) begin
            free     = !(busy[0] && busy[1]);
            exp_tid  = !busy[0] ? 1'b0 : 1'b1;  // Lowest free slot
            accepted = req_valid && req_ready;
            check("req_ready", cmp_t'(req_ready), cmp_t'(l15_ack && free));
            check("l15_req val", cmp_t'(l15_req.val), cmp_t'(req_valid && free));
            check("resp_valid", cmp_t'(resp_valid), cmp_t'(l15_rtrn.val));
            check("l15_req_ack", cmp_t'(l15_req_ack), cmp_t'(l15_rtrn.val && resp_ready));
            if (accepted) begin
                check("l15 request", cmp_t'(l15_req), cmp_t'(expected_req(req, exp_tid)));
                tag_rec[exp_tid] = '{id: req.id, pid: req.pid};
                requests++;
            end
            if (l15_rtrn.val && resp_ready) begin
                check("response", cmp_t'(resp),
                      cmp_t'(expected_resp(l15_rtrn, tag_rec[l15_rtrn.threadid])));
                busy[l15_rtrn.threadid] = 1'b0;
                returns++;
            end
            if (l15_req_ack) begin
                rtrn_done = 1'b1;  // L1.5 drops the return once acked
            end
            if (accepted) begin
                busy[exp_tid] = 1'b1;
            end
        end
    end

    // L1.5 return side sends one return at a time from a random busy slot
    initial begin : l15_model
        logic tid;
        forever begin
            @(posedge clk);
            #10;
            if (random_flow) begin
                resp_ready = ($urandom_range(3) != 0);
                l15_ack    = ($urandom_range(4) != 0);
            end
            if (rtrn_done) begin
                l15_rtrn.val = 1'b0;
                rtrn_done    = 1'b0;
            end
            if (!l15_rtrn.val && rtrn_enable && (busy[0] || busy[1])
                    && $urandom_range(2) != 0) begin
                tid = (busy[0] && busy[1]) ? 1'($urandom_range(1)) : busy[1];
                l15_rtrn.threadid = tid;
                for (int i = 0; i < RTRN_DWORDS; i++) begin
                    l15_rtrn.data[i] = {$urandom, $urandom};
                end
                case ($urandom_range(2))
                    0: l15_rtrn.returntype = L15_LOAD_RET;
                    1: l15_rtrn.returntype = L15_STORE_ACK;
                    default: l15_rtrn.returntype = L15_ERR_RET;
                endcase
                l15_rtrn.val = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin : main
        int        n;
        mem_resp_t held;
        void'($urandom(46));
        req_valid   = 1'b0;
        req         = '0;
        resp_ready  = 1'b1;
        l15_ack     = 1'b1;
        l15_rtrn    = '0;
        busy        = '{1'b0, 1'b0};
        rtrn_done   = 1'b0;
        rtrn_enable = 1'b1;
        random_flow = 1'b0;
        checks      = 0;
        errors      = 0;
        requests    = 0;
        returns     = 0;
        cycles      = 0;
        @(posedge rst_n);
        @(posedge clk);
        #10;

        for (int k = 0; k < NUM_LOADS; k++) begin
            send_req(random_req(1'b0, 8'($urandom)));
        end
        // Aligned 1, 2, 4 and 8 byte stores at every offset, then odd masks
        for (int sz = 1; sz <= 8; sz = sz * 2) begin
            for (int off = 0; off < 8; off += sz) begin
                send_req(random_req(1'b1, 8'(((1 << sz) - 1) << off)));
            end
        end
        foreach (odd_be[i]) begin
            send_req(random_req(1'b1, odd_be[i]));
        end

        // Both slots taken, nothing returned
        wait_idle();
        rtrn_enable = 1'b0;
        send_req(random_req(1'b0, 8'hFF));
        send_req(random_req(1'b0, 8'hFF));
        req       = random_req(1'b0, 8'hFF);
        req_valid = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check("req_ready with slots full", cmp_t'(req_ready), cmp_t'(1'b0));
            check("l15 val with slots full", cmp_t'(l15_req.val), cmp_t'(1'b0));
        end
        @(posedge clk);
        #10;
        n           = returns;
        rtrn_enable = 1'b1;
        while (returns == n) begin
            @(posedge clk);
            #10;
        end
        check("req_ready after a return", cmp_t'(req_ready), cmp_t'(1'b1));
        check("l15 val after a return", cmp_t'(l15_req.val), cmp_t'(1'b1));
        @(negedge clk);
        @(posedge clk);
        #10;
        req_valid = 1'b0;

        // Return held back by resp_ready
        wait_idle();
        rtrn_enable = 1'b0;
        send_req(random_req(1'b0, 8'hFF));
        resp_ready  = 1'b0;
        rtrn_enable = 1'b1;
        do @(negedge clk); while (!l15_rtrn.val);
        held = expected_resp(l15_rtrn, tag_rec[l15_rtrn.threadid]);
        repeat (4) begin
            @(negedge clk);
            check("l15_req_ack under back-pressure", cmp_t'(l15_req_ack), cmp_t'(1'b0));
            check("resp_valid under back-pressure", cmp_t'(resp_valid), cmp_t'(1'b1));
            check("held response", cmp_t'(resp), cmp_t'(held));
        end
        @(posedge clk);
        #10;
        resp_ready = 1'b1;
        @(negedge clk);
        check("l15_req_ack after back-pressure", cmp_t'(l15_req_ack), cmp_t'(1'b1));
        check("delivered response", cmp_t'(resp), cmp_t'(held));
        wait_idle();

        random_flow = 1'b1;
        for (int k = 0; k < NUM_RANDOM; k++) begin
            send_req(random_req(1'($urandom), 8'($urandom)));
        end
        random_flow = 1'b0;
        resp_ready  = 1'b1;
        l15_ack     = 1'b1;
        wait_idle();
        check("all requests returned", cmp_t'(returns), cmp_t'(requests));

        $display("Checks: %0d, errors: %0d, requests: %0d, returns: %0d",
                 checks, errors, requests, returns);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
